/* rtl/uart_macros.svh */
// ------------------------------------------------------------
// Width and reset-value macros for the UART peripheral
// ------------------------------------------------------------

`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Bus data word
`define UART_XLEN 32

// Serial character
`define UART_DATA_SIZE 8

// Clocks-per-bit divider
`define UART_BAUD_DIV_SIZE 16

// Divider after reset, in clocks per bit
`define UART_BAUD_RESET 16

// Receive pin synchronizer depth
`define UART_SYNC_STAGES 2

`endif

/* rtl/uart_pkg.sv */
// ------------------------------------------------------------
// Register index and FSM state types for the UART
// ------------------------------------------------------------

package uart_pkg;

    // Word index of each bus register
    typedef enum logic [3:0] {
        UART_TXDATA_R   = 4'd0,
        UART_RXDATA_R   = 4'd1,
        UART_BAUD_R     = 4'd2,
        UART_STATUS_R   = 4'd3,
        UART_CTRL_R     = 4'd4,
        UART_INT_MASK_R = 4'd5
    } uart_reg_e;

    // Serializer states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    // Deserializer states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

/* rtl/uart_regs.sv */
// ------------------------------------------------------------
// UART register file: bus decode, read mux, status flags,
// interrupt and single-cycle acknowledge
// ------------------------------------------------------------

`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_regs import uart_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    // Bus side
    input  logic                            bus_req_i,
    input  logic                            bus_we_i,
    input  uart_reg_e                       bus_addr_i,
    input  logic [`UART_XLEN-1:0]           bus_wdata_i,
    output logic [`UART_XLEN-1:0]           bus_rdata_o,
    output logic                            bus_ack_o,
    // Transmitter side
    output logic [`UART_DATA_SIZE-1:0]      tx_data_o,
    output logic                            tx_valid_o,
    input  logic                            tx_ready_i,
    output logic                            two_stop_bits_o,
    output logic [`UART_BAUD_DIV_SIZE-1:0]  baud_div_o,
    // Receiver side
    input  logic [`UART_DATA_SIZE-1:0]      rx_data_i,
    input  logic                            rx_valid_i,
    input  logic                            frame_err_i,
    output logic                            irq_o
);

    localparam int STATUS_W = 3;

    logic                           ack_q;
    logic [`UART_XLEN-1:0]          rdata_q;
    logic                           req_accept;
    logic                           wr_accept;
    logic                           rd_accept;

    logic                           txdata_wr;
    logic                           baud_wr;
    logic                           ctrl_wr;
    logic                           mask_wr;
    logic                           rxdata_rd;
    logic                           status_rd;

    logic [`UART_DATA_SIZE-1:0]     tx_data_q;
    logic                           tx_valid_q;
    logic [`UART_BAUD_DIV_SIZE-1:0] baud_q;
    logic                           two_stop_q;
    logic [STATUS_W-1:0]            mask_q;
    logic [`UART_DATA_SIZE-1:0]     rx_byte_q;
    logic                           rx_full_q;
    logic                           frame_err_q;
    logic                           irq_q;
    logic [STATUS_W-1:0]            status;
    logic [`UART_XLEN-1:0]          read_data;

    // ------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------

    // A held request is ignored while ack is high
    assign req_accept = bus_req_i & ~ack_q;
    assign wr_accept  = req_accept & bus_we_i;
    assign rd_accept  = req_accept & ~bus_we_i;

    always_comb begin
        txdata_wr = 1'b0;
        baud_wr   = 1'b0;
        ctrl_wr   = 1'b0;
        mask_wr   = 1'b0;
        if (wr_accept) begin
            case (bus_addr_i)
                UART_TXDATA_R:   txdata_wr = 1'b1;
                UART_BAUD_R:     baud_wr   = 1'b1;
                UART_CTRL_R:     ctrl_wr   = 1'b1;
                UART_INT_MASK_R: mask_wr   = 1'b1;
                default:         ;
            endcase
        end
    end

    // Reads with side effects
    assign rxdata_rd = rd_accept & (bus_addr_i == UART_RXDATA_R);
    assign status_rd = rd_accept & (bus_addr_i == UART_STATUS_R);

    assign status = {frame_err_q, rx_full_q, tx_ready_i};

    always_comb begin
        case (bus_addr_i)
            UART_TXDATA_R:   read_data = {~tx_ready_i, {(`UART_XLEN-1){1'b0}}};
            UART_RXDATA_R:   read_data = {~rx_full_q,
                                          {(`UART_XLEN-`UART_DATA_SIZE-1){1'b0}},
                                          rx_byte_q};
            UART_BAUD_R:     read_data = {{(`UART_XLEN-`UART_BAUD_DIV_SIZE){1'b0}}, baud_q};
            UART_STATUS_R:   read_data = {{(`UART_XLEN-STATUS_W){1'b0}}, status};
            UART_CTRL_R:     read_data = {{(`UART_XLEN-1){1'b0}}, two_stop_q};
            UART_INT_MASK_R: read_data = {{(`UART_XLEN-STATUS_W){1'b0}}, mask_q};
            default:         read_data = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Bus response
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata_q <= read_data;
        end
    end

    // ------------------------------------------------------------
    // Registers and status flags
    // ------------------------------------------------------------

    // Write while the serializer is busy is dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_valid_q  <= 1'b0;
            baud_q      <= `UART_BAUD_DIV_SIZE'(`UART_BAUD_RESET);
            two_stop_q  <= 1'b0;
            mask_q      <= '0;
            rx_byte_q   <= '0;
            rx_full_q   <= 1'b0;
            frame_err_q <= 1'b0;
            irq_q       <= 1'b0;
        end else begin
            tx_valid_q <= txdata_wr & tx_ready_i;
            if (baud_wr) begin
                baud_q <= bus_wdata_i[`UART_BAUD_DIV_SIZE-1:0];
            end
            if (ctrl_wr) begin
                two_stop_q <= bus_wdata_i[0];
            end
            if (mask_wr) begin
                mask_q <= bus_wdata_i[STATUS_W-1:0];
            end
            if (rx_valid_i) begin
                rx_byte_q <= rx_data_i;
            end
            // Set wins over a clearing read in the same cycle
            if (rx_valid_i) begin
                rx_full_q <= 1'b1;
            end else if (rxdata_rd) begin
                rx_full_q <= 1'b0;
            end
            if (frame_err_i) begin
                frame_err_q <= 1'b1;
            end else if (status_rd) begin
                frame_err_q <= 1'b0;
            end
            irq_q <= |(status & mask_q);
        end
    end

    always_ff @(posedge clk) begin
        if (txdata_wr) begin
            tx_data_q <= bus_wdata_i[`UART_DATA_SIZE-1:0];
        end
    end

    assign bus_ack_o       = ack_q;
    assign bus_rdata_o     = rdata_q;
    assign tx_data_o       = tx_data_q;
    assign tx_valid_o      = tx_valid_q;
    assign two_stop_bits_o = two_stop_q;
    assign baud_div_o      = baud_q;
    assign irq_o           = irq_q;

endmodule

/* rtl/uart_tx.sv */
// ------------------------------------------------------------
// UART serializer, 8 data bits with one or two stop bits
// ------------------------------------------------------------

`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_tx import uart_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [`UART_DATA_SIZE-1:0]      tx_data_i,
    input  logic                            tx_valid_i,
    input  logic                            two_stop_bits_i,
    input  logic [`UART_BAUD_DIV_SIZE-1:0]  baud_div_i,
    output logic                            tx_ready_o,
    output logic                            txd_o
);

    tx_state_e                      state_q;
    logic [`UART_BAUD_DIV_SIZE-1:0] baud_cnt_q;
    logic [`UART_BAUD_DIV_SIZE-1:0] baud_last;
    logic [2:0]                     bit_cnt_q;
    logic [`UART_DATA_SIZE-1:0]     shift_q;
    logic                           two_stop_q;
    logic                           txd_q;
    logic                           bit_done;

    assign baud_last  = baud_div_i - `UART_BAUD_DIV_SIZE'(1);
    assign bit_done   = (baud_cnt_q == baud_last);
    assign tx_ready_o = (state_q == TX_IDLE);

    // ------------------------------------------------------------
    // Frame FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= TX_IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            txd_q      <= 1'b1;
        end else begin
            if (state_q == TX_IDLE || bit_done) begin
                baud_cnt_q <= '0;
            end else begin
                baud_cnt_q <= baud_cnt_q + 1'b1;
            end
            case (state_q)
                TX_IDLE: begin
                    if (tx_valid_i) begin
                        state_q <= TX_START;
                        txd_q   <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state_q   <= TX_DATA;
                        bit_cnt_q <= '0;
                        txd_q     <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (bit_cnt_q == 3'd7) begin
                            state_q   <= TX_STOP;
                            bit_cnt_q <= '0;
                            txd_q     <= 1'b1;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            txd_q     <= shift_q[0];
                        end
                    end
                end
                default: begin
                    // Second stop bit reuses the bit counter
                    if (bit_done) begin
                        if (two_stop_q && bit_cnt_q == 3'd0) begin
                            bit_cnt_q <= 3'd1;
                        end else begin
                            state_q <= TX_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // Byte and stop setting held for the whole frame
    always_ff @(posedge clk) begin
        if (tx_ready_o && tx_valid_i) begin
            shift_q    <= tx_data_i;
            two_stop_q <= two_stop_bits_i;
        end else if (bit_done && (state_q == TX_START || state_q == TX_DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign txd_o = txd_q;

endmodule

/* rtl/uart_rx.sv */
// ------------------------------------------------------------
// UART deserializer with pin synchronizer, mid-bit sampling
// and stop-bit framing check
// ------------------------------------------------------------

`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_rx import uart_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            rxd_i,
    input  logic [`UART_BAUD_DIV_SIZE-1:0]  baud_div_i,
    output logic [`UART_DATA_SIZE-1:0]      rx_data_o,
    output logic                            rx_valid_o,
    output logic                            frame_err_o
);

    logic [`UART_SYNC_STAGES-1:0]   sync_q;
    logic                           rxd_s;
    logic                           rxd_prev_q;
    logic                           fall;

    rx_state_e                      state_q;
    logic [`UART_BAUD_DIV_SIZE-1:0] baud_cnt_q;
    logic [`UART_BAUD_DIV_SIZE-1:0] baud_last;
    logic [`UART_BAUD_DIV_SIZE-1:0] half_last;
    logic                           full_done;
    logic                           half_done;
    logic [2:0]                     bit_cnt_q;
    logic [`UART_DATA_SIZE-1:0]     shift_q;
    logic                           rx_valid_q;
    logic                           frame_err_q;

    // ------------------------------------------------------------
    // Pin synchronizer and edge detect
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q     <= '1;
            rxd_prev_q <= 1'b1;
        end else begin
            sync_q     <= {sync_q[`UART_SYNC_STAGES-2:0], rxd_i};
            rxd_prev_q <= rxd_s;
        end
    end

    assign rxd_s = sync_q[`UART_SYNC_STAGES-1];
    assign fall  = rxd_prev_q & ~rxd_s;

    assign baud_last = baud_div_i - `UART_BAUD_DIV_SIZE'(1);
    assign half_last = (baud_div_i >> 1) - `UART_BAUD_DIV_SIZE'(1);
    assign full_done = (baud_cnt_q == baud_last);
    assign half_done = (baud_cnt_q == half_last);

    // ------------------------------------------------------------
    // Receive FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= RX_IDLE;
            baud_cnt_q  <= '0;
            bit_cnt_q   <= '0;
            rx_valid_q  <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            rx_valid_q  <= 1'b0;
            frame_err_q <= 1'b0;
            baud_cnt_q  <= baud_cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    baud_cnt_q <= '0;
                    if (fall) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // Start must still be low at its midpoint
                    if (half_done) begin
                        baud_cnt_q <= '0;
                        bit_cnt_q  <= '0;
                        state_q    <= rxd_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (full_done) begin
                        baud_cnt_q <= '0;
                        bit_cnt_q  <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (full_done) begin
                        rx_valid_q  <= rxd_s;
                        frame_err_q <= ~rxd_s;
                        state_q     <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && full_done) begin
            shift_q <= {rxd_s, shift_q[`UART_DATA_SIZE-1:1]};
        end
    end

    assign rx_data_o   = shift_q;
    assign rx_valid_o  = rx_valid_q;
    assign frame_err_o = frame_err_q;

endmodule

/* rtl/uart_top.sv */
// ------------------------------------------------------------
// UART peripheral top: register file, serializer, deserializer
// ------------------------------------------------------------

`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_top import uart_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    // Processor data bus
    input  logic                    bus_req_i,
    input  logic                    bus_we_i,
    input  uart_reg_e               bus_addr_i,
    input  logic [`UART_XLEN-1:0]   bus_wdata_i,
    output logic [`UART_XLEN-1:0]   bus_rdata_o,
    output logic                    bus_ack_o,
    output logic                    uart_irq_o,
    // Serial pins
    input  logic                    uart_rxd_i,
    output logic                    uart_txd_o
);

    logic [`UART_DATA_SIZE-1:0]     tx_data;
    logic                           tx_valid;
    logic                           tx_ready;
    logic                           two_stop_bits;
    logic [`UART_BAUD_DIV_SIZE-1:0] baud_div;
    logic [`UART_DATA_SIZE-1:0]     rx_data;
    logic                           rx_valid;
    logic                           frame_err;

    uart_regs i_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .bus_req_i       (bus_req_i),
        .bus_we_i        (bus_we_i),
        .bus_addr_i      (bus_addr_i),
        .bus_wdata_i     (bus_wdata_i),
        .bus_rdata_o     (bus_rdata_o),
        .bus_ack_o       (bus_ack_o),
        .tx_data_o       (tx_data),
        .tx_valid_o      (tx_valid),
        .tx_ready_i      (tx_ready),
        .two_stop_bits_o (two_stop_bits),
        .baud_div_o      (baud_div),
        .rx_data_i       (rx_data),
        .rx_valid_i      (rx_valid),
        .frame_err_i     (frame_err),
        .irq_o           (uart_irq_o)
    );

    uart_tx i_tx (
        .clk             (clk),
        .rst_n           (rst_n),
        .tx_data_i       (tx_data),
        .tx_valid_i      (tx_valid),
        .two_stop_bits_i (two_stop_bits),
        .baud_div_i      (baud_div),
        .tx_ready_o      (tx_ready),
        .txd_o           (uart_txd_o)
    );

    uart_rx i_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd_i       (uart_rxd_i),
        .baud_div_i  (baud_div),
        .rx_data_o   (rx_data),
        .rx_valid_o  (rx_valid),
        .frame_err_o (frame_err)
    );

endmodule

/* testbench/uart_checker.sv */
// ------------------------------------------------------------
// Testbench monitor: txd frame decoder, bus read comparison
// and error counters
// ------------------------------------------------------------

`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    bus_we_i,
    input  logic [3:0]              bus_addr_i,
    input  logic [`UART_XLEN-1:0]   bus_rdata_i,
    input  logic                    bus_ack_i,
    input  logic                    txd_i
);

    string                  test_name = "none";
    int                     frame_errors = 0;
    int                     read_errors = 0;
    int                     value_errors = 0;
    int                     timeout_errors = 0;
    int                     frames_done = 0;

    // Expected frames and reads, in issue order
    logic [10:0]            frame_q[$];
    int                     len_q[$];
    int                     div_q[$];
    logic [`UART_XLEN-1:0]  rd_exp_q[$];
    logic [`UART_XLEN-1:0]  rd_mask_q[$];

    task automatic expect_frame(input logic [10:0] bits, input int len, input int div);
        frame_q.push_back(bits);
        len_q.push_back(len);
        div_q.push_back(div);
    endtask

    task automatic expect_read(input logic [`UART_XLEN-1:0] exp,
                               input logic [`UART_XLEN-1:0] mask);
        rd_exp_q.push_back(exp);
        rd_mask_q.push_back(mask);
    endtask

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("error %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_at_least(input string what, input int min, input int act);
        if (act < min) begin
            value_errors++;
            $display("error %s %s: expected at least %0d actual %0d",
                     test_name, what, min, act);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("%s: timed out %s", test_name, what);
    endtask

    // ------------------------------------------------------------
    // Transmit pin decoder sampling each bit at its middle
    // ------------------------------------------------------------
    initial begin : tx_monitor
        logic        txd_prev;
        logic [10:0] bits;
        int          len;
        int          div;
        txd_prev = 1'b1;
        forever begin
            @(posedge clk);
            if (rst_n && txd_prev && !txd_i) begin
                if (frame_q.size() == 0) begin
                    frame_errors++;
                    $display("%s: frame started on txd while none was expected", test_name);
                end else begin
                    bits = frame_q.pop_front();
                    len  = len_q.pop_front();
                    div  = div_q.pop_front();
                    repeat (div / 2) @(posedge clk);
                    for (int k = 0; k < len; k++) begin
                        if (k > 0) begin
                            repeat (div) @(posedge clk);
                        end
                        if (txd_i !== bits[k]) begin
                            frame_errors++;
                            $display("error %s frame bit %0d: expected %b actual %b",
                                     test_name, k, bits[k], txd_i);
                        end
                    end
                    frames_done++;
                end
            end
            txd_prev = txd_i;
        end
    end

    // ------------------------------------------------------------
    // Bus read comparison at the acknowledge cycle
    // ------------------------------------------------------------
    always @(posedge clk) begin : read_monitor
        logic [`UART_XLEN-1:0] exp;
        logic [`UART_XLEN-1:0] mask;
        if (rst_n && bus_ack_i && !bus_we_i) begin
            if (rd_exp_q.size() == 0) begin
                read_errors++;
                $display("%s: bus read acknowledged with no expected value", test_name);
            end else begin
                exp  = rd_exp_q.pop_front();
                mask = rd_mask_q.pop_front();
                if ((bus_rdata_i & mask) !== (exp & mask)) begin
                    read_errors++;
                    $display("error %s read of register %0d: expected %h actual %h",
                             test_name, bus_addr_i, exp, bus_rdata_i);
                end
            end
        end
    end

endmodule

/* testbench/uart_tb.sv */
// ------------------------------------------------------------
// UART testbench: clock, reset, bus tasks, serial driver,
// frame reference and test sequence
// ------------------------------------------------------------

`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_tb import uart_pkg::*;;

    localparam int CLK_PERIOD    = 4;
    localparam int ACK_TIMEOUT   = 20;
    localparam int POLL_LIMIT    = 500;
    localparam int CYCLE_TIMEOUT = 5000;

    logic                   clk;
    logic                   rst_n;
    logic                   bus_req;
    logic                   bus_we;
    uart_reg_e              bus_addr;
    logic [`UART_XLEN-1:0]  bus_wdata;
    logic [`UART_XLEN-1:0]  bus_rdata;
    logic                   bus_ack;
    logic                   uart_irq;
    logic                   uart_rxd;
    logic                   uart_txd;
    logic [31:0]            lcg_state = 32'ha310aeb9;

    uart_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req_i   (bus_req),
        .bus_we_i    (bus_we),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .bus_rdata_o (bus_rdata),
        .bus_ack_o   (bus_ack),
        .uart_irq_o  (uart_irq),
        .uart_rxd_i  (uart_rxd),
        .uart_txd_o  (uart_txd)
    );

    uart_checker i_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_we_i    (bus_we),
        .bus_addr_i  (bus_addr),
        .bus_rdata_i (bus_rdata),
        .bus_ack_i   (bus_ack),
        .txd_i       (uart_txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Bit k of the result is the k-th bit on the line
    // Start first, then data LSB first, then the stop bits
    function automatic logic [10:0] expected_frame(input logic [7:0] data, input logic two_stop);
        logic [10:0] bits;
        bits    = '0;
        bits[0] = 1'b0;
        for (int i = 0; i < `UART_DATA_SIZE; i++) begin
            bits[i + 1] = data[i];
        end
        bits[9]  = 1'b1;
        bits[10] = two_stop;
        return bits;
    endfunction

    function automatic int frame_length(input logic two_stop);
        return two_stop ? 11 : 10;
    endfunction

    task automatic finish_run();
        int total;
        total = i_checker.frame_errors + i_checker.read_errors
              + i_checker.value_errors + i_checker.timeout_errors;
        $display("error counts: frame %0d, read %0d, value %0d, timeout %0d",
                 i_checker.frame_errors, i_checker.read_errors,
                 i_checker.value_errors, i_checker.timeout_errors);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // ------------------------------------------------------------
    // Bus access
    // ------------------------------------------------------------
    task automatic wait_ack();
        int n;
        n = 0;
        @(posedge clk);
        while (!bus_ack && n < ACK_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!bus_ack) begin
            i_checker.report_timeout("waiting for bus ack");
            finish_run();
        end
        bus_req <= 1'b0;
    endtask

    task automatic bus_write(input uart_reg_e addr, input logic [31:0] data);
        @(posedge clk);
        bus_req   <= 1'b1;
        bus_we    <= 1'b1;
        bus_addr  <= addr;
        bus_wdata <= data;
        wait_ack();
    endtask

    // Mask selects the bits the checker compares
    task automatic bus_read(input uart_reg_e addr, input logic [31:0] exp,
                            input logic [31:0] mask, output logic [31:0] data);
        i_checker.expect_read(exp, mask);
        @(posedge clk);
        bus_req  <= 1'b1;
        bus_we   <= 1'b0;
        bus_addr <= addr;
        wait_ack();
        data = bus_rdata;
    endtask

    task automatic poll_reg(input uart_reg_e addr, input int bit_idx, input logic level,
                            input string what);
        logic [31:0] d;
        int          n;
        n = 0;
        bus_read(addr, '0, '0, d);
        while (d[bit_idx] !== level && n < POLL_LIMIT) begin
            bus_read(addr, '0, '0, d);
            n++;
        end
        if (d[bit_idx] !== level) begin
            i_checker.report_timeout(what);
            finish_run();
        end
    endtask

    task automatic wait_frames(input int count);
        int n;
        n = 0;
        while (i_checker.frames_done < count && n < CYCLE_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (i_checker.frames_done < count) begin
            i_checker.report_timeout("waiting for transmit frames");
            finish_run();
        end
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (uart_irq !== level && n < CYCLE_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (uart_irq !== level) begin
            i_checker.report_timeout("waiting for the interrupt line");
            finish_run();
        end
    endtask

    // Drives one 8N1 frame on rxd with the stop bit level given by the caller
    task automatic send_frame(input logic [7:0] data, input logic stop_level, input int div);
        logic [10:0] bits;
        bits    = expected_frame(data, 1'b0);
        bits[9] = stop_level;
        @(posedge clk);
        for (int i = 0; i < 10; i++) begin
            uart_rxd <= bits[i];
            repeat (div) @(posedge clk);
        end
        uart_rxd <= 1'b1;
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin : test_sequence
        logic [31:0] val;
        logic [31:0] d;
        logic [15:0] baud;
        logic [7:0]  data;
        int          div;
        int          sent;
        time         t_start;
        bus_req   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = UART_TXDATA_R;
        bus_wdata = '0;
        uart_rxd  = 1'b1;
        rst_n     = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        i_checker.test_name = "reset values";
        bus_read(UART_BAUD_R, `UART_BAUD_RESET, '1, d);
        bus_read(UART_STATUS_R, 32'd1, '1, d);
        bus_read(UART_CTRL_R, 32'd0, '1, d);
        bus_read(UART_INT_MASK_R, 32'd0, '1, d);
        i_checker.compare("irq", 32'd0, uart_irq);

        i_checker.test_name = "register readback";
        for (int i = 0; i < 4; i++) begin
            val = lcg_next();
            if (val[15:0] < 16'd4) begin
                val[2] = 1'b1;
            end
            baud = val[15:0];
            bus_write(UART_BAUD_R, val);
            bus_read(UART_BAUD_R, {16'd0, baud}, '1, d);
            val = lcg_next();
            bus_write(UART_CTRL_R, val);
            bus_read(UART_CTRL_R, {31'd0, val[0]}, '1, d);
            val = lcg_next();
            bus_write(UART_INT_MASK_R, val);
            bus_read(UART_INT_MASK_R, {29'd0, val[2:0]}, '1, d);
        end
        bus_write(UART_RXDATA_R, lcg_next());
        bus_read(UART_RXDATA_R, 32'h8000_0000, '1, d);
        bus_read(UART_STATUS_R, 32'd1, '1, d);
        bus_read(UART_BAUD_R, {16'd0, baud}, '1, d);
        bus_write(UART_INT_MASK_R, 32'd0);

        // Busy time covers start, data and every stop bit at the set divider
        i_checker.test_name = "transmit";
        sent = 0;
        for (int s = 0; s < 2; s++) begin
            for (int v = 0; v < 2; v++) begin
                div = (v == 0) ? 6 : 11;
                bus_write(UART_CTRL_R, s);
                bus_write(UART_BAUD_R, div);
                for (int k = 0; k < 3; k++) begin
                    val  = lcg_next();
                    data = val[31:24];
                    poll_reg(UART_TXDATA_R, 31, 1'b0, "waiting for TXDATA not busy");
                    i_checker.expect_frame(expected_frame(data, s[0]), frame_length(s[0]), div);
                    bus_write(UART_TXDATA_R, {val[31:8], data});
                    t_start = $time;
                    sent++;
                    poll_reg(UART_TXDATA_R, 31, 1'b0, "waiting for the last stop bit");
                    i_checker.check_at_least("busy cycles", frame_length(s[0]) * div,
                                             int'(($time - t_start) / CLK_PERIOD));
                end
                wait_frames(sent);
                poll_reg(UART_TXDATA_R, 31, 1'b0, "waiting for the last stop bit");
            end
        end

        i_checker.test_name = "receive";
        bus_write(UART_CTRL_R, 32'd0);
        bus_write(UART_BAUD_R, 32'd10);
        for (int k = 0; k < 3; k++) begin
            val  = lcg_next();
            data = val[31:24];
            send_frame(data, 1'b1, 10);
            poll_reg(UART_STATUS_R, 1, 1'b1, "waiting for rx_full");
            bus_read(UART_RXDATA_R, {24'd0, data}, '1, d);
            bus_read(UART_RXDATA_R, {1'b1, 23'd0, data}, '1, d);
        end

        // Low stop bit, interrupt enabled on the frame error flag only
        i_checker.test_name = "framing error";
        bus_write(UART_INT_MASK_R, 32'd4);
        i_checker.compare("irq before frame", 32'd0, uart_irq);
        val = lcg_next();
        send_frame(val[31:24], 1'b0, 10);
        wait_irq(1'b1);
        bus_read(UART_STATUS_R, 32'd5, '1, d);
        bus_read(UART_STATUS_R, 32'd1, '1, d);
        i_checker.compare("irq after STATUS read", 32'd0, uart_irq);

        finish_run();
    end

endmodule

/* sources.f */
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
testbench/uart_checker.sv
testbench/uart_tb.sv
